//--- src/cm_status_pkg.sv
`default_nettype none

package cm_status_pkg;

    typedef logic [1:0] paper_level_t;
    typedef logic [1:0] pressure_t;
    typedef logic [2:0] drink_t;       // 0 mocha .. 4 drip
    typedef logic [1:0] cup_size_t;    // 10, 16, 20 oz
    typedef logic [1:0] brew_state_t;  // Idle, heating, brewing, ready

    // Paper filter level codes
    localparam paper_level_t PAPER_NOT_INSTALLED = 2'b00;
    localparam paper_level_t PAPER_EMPTY         = 2'b01;
    localparam paper_level_t PAPER_ALMOST_EMPTY  = 2'b10;
    localparam paper_level_t PAPER_FULL          = 2'b11;

    // Water pressure codes
    localparam pressure_t PRESSURE_LOW    = 2'b00;
    localparam pressure_t PRESSURE_NORMAL = 2'b01;
    localparam pressure_t PRESSURE_HIGH   = 2'b10;
    localparam pressure_t PRESSURE_FAULT  = 2'b11;

    typedef struct packed {
        paper_level_t paper_level;
        logic         bin0_empty;
        logic         bin1_empty;
        logic         creamer_empty;
        logic         cocoa_empty;
        pressure_t    w_pressure;
        logic         status_ok;     // Low means hardware fault
    } cm_sensors_t;

    typedef struct packed {
        logic        flavor;
        drink_t      drink;
        cup_size_t   size;
        brew_state_t brew_state;
    } cm_selection_t;

    typedef enum logic [3:0] {
        msg_normal         = 4'd0,
        msg_paper_low      = 4'd1,
        msg_paper_empty    = 4'd2,
        msg_paper_missing  = 4'd3,
        msg_bin0_low       = 4'd4,
        msg_bin1_low       = 4'd5,
        msg_creamer_low    = 4'd6,
        msg_cocoa_low      = 4'd7,
        msg_pressure_fault = 4'd8,
        msg_pressure_high  = 4'd9,
        msg_pressure_low   = 4'd10,
        msg_hw_status      = 4'd11
    } msg_id_e;

endpackage

`default_nettype wire

//--- src/cm_lcd_pkg.sv
`default_nettype none

package cm_lcd_pkg;

    typedef logic [7:0]   lcd_char_t;
    typedef logic [3:0]   lcd_col_t;
    typedef logic [127:0] lcd_line_t;   // 16 characters, column 0 in the top byte
    typedef logic [23:0]  lcd_dly_t;    // Delay in clock ticks

    typedef struct packed {
        logic      rs;     // 0 instruction, 1 data
        lcd_char_t data;
    } lcd_cmd_t;

    // ================================================
    // HD44780 instruction bytes
    // ================================================
    localparam lcd_char_t CMD_FUNC_SET_8BIT  = 8'h30;
    localparam lcd_char_t CMD_FUNC_SET_2LINE = 8'h38;
    localparam lcd_char_t CMD_DISPLAY_OFF    = 8'h08;
    localparam lcd_char_t CMD_CLEAR          = 8'h01;
    localparam lcd_char_t CMD_ENTRY_MODE     = 8'h06;  // Increment, no shift
    localparam lcd_char_t CMD_DISPLAY_ON     = 8'h0C;  // Cursor off
    localparam lcd_char_t CMD_LINE1_ADDR     = 8'h80;
    localparam lcd_char_t CMD_LINE2_ADDR     = 8'hC0;

    // ================================================
    // Delays in microseconds
    // ================================================
    localparam int unsigned DLY_POWERUP_US = 15000;
    localparam int unsigned DLY_INIT_US    = 5000;
    localparam int unsigned DLY_SHORT_US   = 100;
    localparam int unsigned DLY_CMD_US     = 100;
    localparam int unsigned DLY_CLEAR_US   = 1500;

endpackage

`default_nettype wire

//--- src/cm_status_select.sv
`timescale 1ns/1ps
`default_nettype none

module cm_status_select #(
    parameter int unsigned WARN_TOGGLE_TICKS = 50_000_000
) (
    input  wire logic                       CLOCK_50,
    input  wire logic                       rst,
    input  wire cm_status_pkg::cm_sensors_t sensors,
    output cm_status_pkg::msg_id_e          msg_id
);

    localparam int unsigned CNT_W = $clog2(WARN_TOGGLE_TICKS);

    logic                   err_present;
    logic                   warn_present;
    logic                   show_warn;     // Alternation phase
    cm_status_pkg::msg_id_e err_id;
    cm_status_pkg::msg_id_e warn_id;
    logic [CNT_W-1:0]       warn_cnt;

    // Errors from the highest priority down
    always_comb begin
        err_present = 1'b1;
        err_id      = cm_status_pkg::msg_normal;
        if (sensors.paper_level == cm_status_pkg::PAPER_NOT_INSTALLED)
            err_id = cm_status_pkg::msg_paper_missing;
        else if (sensors.paper_level == cm_status_pkg::PAPER_EMPTY)
            err_id = cm_status_pkg::msg_paper_empty;
        else if (sensors.w_pressure == cm_status_pkg::PRESSURE_FAULT)
            err_id = cm_status_pkg::msg_pressure_fault;
        else if (sensors.w_pressure == cm_status_pkg::PRESSURE_HIGH)
            err_id = cm_status_pkg::msg_pressure_high;
        else if (!sensors.status_ok)
            err_id = cm_status_pkg::msg_hw_status;
        else
            err_present = 1'b0;
    end

    // Warnings
    always_comb begin
        warn_present = 1'b1;
        warn_id      = cm_status_pkg::msg_normal;
        if (sensors.paper_level == cm_status_pkg::PAPER_ALMOST_EMPTY)
            warn_id = cm_status_pkg::msg_paper_low;
        else if (sensors.w_pressure == cm_status_pkg::PRESSURE_LOW)
            warn_id = cm_status_pkg::msg_pressure_low;
        else if (sensors.bin0_empty)
            warn_id = cm_status_pkg::msg_bin0_low;
        else if (sensors.bin1_empty)
            warn_id = cm_status_pkg::msg_bin1_low;
        else if (sensors.creamer_empty)
            warn_id = cm_status_pkg::msg_creamer_low;
        else if (sensors.cocoa_empty)
            warn_id = cm_status_pkg::msg_cocoa_low;
        else
            warn_present = 1'b0;
    end

    // Phase restarts at normal whenever the warning stops being the top item
    always_ff @(posedge CLOCK_50) begin
        if (rst || err_present || !warn_present) begin
            warn_cnt  <= '0;
            show_warn <= 1'b0;
        end else if (warn_cnt == CNT_W'(WARN_TOGGLE_TICKS - 1)) begin
            warn_cnt  <= '0;
            show_warn <= ~show_warn;
        end else begin
            warn_cnt <= warn_cnt + 1'b1;
        end
    end

    assign msg_id = err_present                ? err_id  :
                    (warn_present && show_warn) ? warn_id :
                                                  cm_status_pkg::msg_normal;

endmodule

`default_nettype wire

//--- src/cm_msg_text.sv
`timescale 1ns/1ps
`default_nettype none

module cm_msg_text (
    input  wire cm_status_pkg::msg_id_e       msg_id,
    input  wire cm_status_pkg::cm_selection_t selection,
    input  wire logic                         line,      // 0 top, 1 bottom
    input  wire cm_lcd_pkg::lcd_col_t         col,
    output cm_lcd_pkg::lcd_char_t             char_out
);

    cm_lcd_pkg::lcd_char_t flavor_ch;
    cm_lcd_pkg::lcd_line_t text;

    // Short literals arrive right-aligned with zero bytes on the left
    function automatic cm_lcd_pkg::lcd_line_t pad16(input cm_lcd_pkg::lcd_line_t s);
        cm_lcd_pkg::lcd_line_t r;
        r = s;
        for (int i = 0; i < 16; i++) begin
            if (r[127:120] == 8'h00)
                r = {r[119:0], 8'h20};
        end
        return r;
    endfunction

    function automatic logic [39:0] drink_name(input cm_status_pkg::drink_t drink);
        case (drink)
            3'd0:    return "MOCHA";
            3'd1:    return "LATTE";
            3'd2:    return "ESPR ";
            3'd3:    return "AMER ";
            3'd4:    return "DRIP ";
            default: return "UNKN ";
        endcase
    endfunction

    function automatic logic [31:0] size_name(input cm_status_pkg::cup_size_t size);
        case (size)
            2'd0:    return "10oz";
            2'd1:    return "16oz";
            2'd2:    return "20oz";
            default: return "??oz";
        endcase
    endfunction

    function automatic cm_lcd_pkg::lcd_line_t brew_text(input cm_status_pkg::brew_state_t st);
        case (st)
            2'd0:    return "Press START";
            2'd1:    return "HEATING...";
            2'd2:    return "BREWING...";
            default: return "READY";
        endcase
    endfunction

    // ================================================
    // Fixed warning and error texts
    // ================================================
    function automatic cm_lcd_pkg::lcd_line_t fixed_line1(input cm_status_pkg::msg_id_e id);
        case (id)
            cm_status_pkg::msg_paper_low:      return "Paper Filter Alm";
            cm_status_pkg::msg_paper_empty:    return "Paper Filter";
            cm_status_pkg::msg_paper_missing:  return "Paper Filter NOT";
            cm_status_pkg::msg_bin0_low:       return "Coffee Bin 0 Alm";
            cm_status_pkg::msg_bin1_low:       return "Coffee Bin 1 Alm";
            cm_status_pkg::msg_creamer_low:    return "Non-Dairy Crmr A";
            cm_status_pkg::msg_cocoa_low:      return "Chocolate Pwdr A";
            cm_status_pkg::msg_pressure_fault: return "Water Pressure";
            cm_status_pkg::msg_pressure_high:  return "High Water";
            cm_status_pkg::msg_pressure_low:   return "Low Water";
            cm_status_pkg::msg_hw_status:      return "Hardware Status";
            default:                           return "";
        endcase
    endfunction

    function automatic cm_lcd_pkg::lcd_line_t fixed_line2(input cm_status_pkg::msg_id_e id);
        case (id)
            cm_status_pkg::msg_paper_low,
            cm_status_pkg::msg_bin0_low,
            cm_status_pkg::msg_bin1_low:       return "st Empty";
            cm_status_pkg::msg_creamer_low,
            cm_status_pkg::msg_cocoa_low:      return "lmst Empty";
            cm_status_pkg::msg_paper_empty:    return "Empty";
            cm_status_pkg::msg_paper_missing:  return "INSTALLED";
            cm_status_pkg::msg_pressure_fault: return "Error!";
            cm_status_pkg::msg_pressure_high,
            cm_status_pkg::msg_pressure_low:   return "Pressure";
            cm_status_pkg::msg_hw_status:      return "Error - Service";
            default:                           return "";
        endcase
    endfunction

    assign flavor_ch = selection.flavor ? "2" : "1";

    always_comb begin
        if (msg_id != cm_status_pkg::msg_normal)
            text = pad16(line ? fixed_line2(msg_id) : fixed_line1(msg_id));
        else if (line)
            text = pad16(brew_text(selection.brew_state));
        else
            text = {"C", flavor_ch, " ", drink_name(selection.drink), " ",
                    size_name(selection.size), "   "};  // Exactly 16 wide
    end

    assign char_out = text[8 * (4'd15 - col) +: 8];

endmodule

`default_nettype wire

//--- src/cm_lcd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cm_lcd_sequencer #(
    parameter int unsigned TICKS_PER_US = 50
) (
    input  wire logic                         CLOCK_50,
    input  wire logic                         rst,
    input  wire cm_status_pkg::msg_id_e       msg_id,
    input  wire cm_status_pkg::cm_selection_t selection,
    input  wire cm_lcd_pkg::lcd_char_t        char_in,   // Text for current line and col
    input  wire logic                         busy,
    output cm_lcd_pkg::lcd_cmd_t              cmd,
    output logic                              send,
    output logic                              line,
    output cm_lcd_pkg::lcd_col_t              col
);

    typedef enum logic [2:0] {
        st_powerup,
        st_init,
        st_addr,
        st_data,
        st_idle
    } seq_state_e;

    seq_state_e                   state;
    cm_lcd_pkg::lcd_dly_t         dly_cnt;
    logic [2:0]                   init_idx;
    logic                         pending;     // Screen is stale
    logic                         ready;
    logic                         changed;
    logic                         clear_sent;
    cm_status_pkg::msg_id_e       prev_msg;
    cm_status_pkg::cm_selection_t prev_sel;

    function automatic cm_lcd_pkg::lcd_dly_t us_to_ticks(input int unsigned us);
        return cm_lcd_pkg::lcd_dly_t'(us * TICKS_PER_US);
    endfunction

    // ================================================
    // Power-up instruction table
    // ================================================
    function automatic cm_lcd_pkg::lcd_char_t init_byte(input logic [2:0] idx);
        case (idx)
            3'd0, 3'd1, 3'd2: return cm_lcd_pkg::CMD_FUNC_SET_8BIT;
            3'd3:             return cm_lcd_pkg::CMD_FUNC_SET_2LINE;
            3'd4:             return cm_lcd_pkg::CMD_DISPLAY_OFF;
            3'd5:             return cm_lcd_pkg::CMD_CLEAR;
            3'd6:             return cm_lcd_pkg::CMD_ENTRY_MODE;
            default:          return cm_lcd_pkg::CMD_DISPLAY_ON;
        endcase
    endfunction

    // Wait after each table entry before the next command
    function automatic int unsigned init_wait_us(input logic [2:0] idx);
        case (idx)
            3'd0:       return cm_lcd_pkg::DLY_INIT_US;
            3'd1, 3'd2: return cm_lcd_pkg::DLY_SHORT_US;
            3'd5:       return cm_lcd_pkg::DLY_CLEAR_US;
            default:    return cm_lcd_pkg::DLY_CMD_US;
        endcase
    endfunction

    assign ready      = (dly_cnt == '0) && !busy;
    assign changed    = (msg_id != prev_msg) || (selection != prev_sel);
    assign clear_sent = send && !cmd.rs && (cmd.data == cm_lcd_pkg::CMD_CLEAR);

    // A new change wins over the clear
    always_ff @(posedge CLOCK_50) begin
        prev_msg <= msg_id;
        prev_sel <= selection;
        if (rst)
            pending <= 1'b0;
        else if (changed)
            pending <= 1'b1;
        else if (clear_sent)
            pending <= 1'b0;
    end

    // ================================================
    // Init, write loop and redraw FSM
    // ================================================
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            state    <= st_powerup;
            dly_cnt  <= us_to_ticks(cm_lcd_pkg::DLY_POWERUP_US);
            init_idx <= '0;
            line     <= 1'b0;
            col      <= '0;
            send     <= 1'b0;
        end else begin
            send <= 1'b0;
            if (dly_cnt != '0)
                dly_cnt <= dly_cnt - 1'b1;

            case (state)
                st_powerup: begin
                    if (ready)
                        state <= st_init;
                end

                st_init: begin
                    if (ready) begin
                        send     <= 1'b1;
                        cmd      <= '{rs: 1'b0, data: init_byte(init_idx)};
                        dly_cnt  <= us_to_ticks(init_wait_us(init_idx));
                        init_idx <= init_idx + 1'b1;
                        if (init_idx == 3'd7)
                            state <= st_addr;
                    end
                end

                st_addr: begin
                    if (ready) begin
                        send    <= 1'b1;
                        cmd     <= '{rs: 1'b0, data: line ? cm_lcd_pkg::CMD_LINE2_ADDR
                                                          : cm_lcd_pkg::CMD_LINE1_ADDR};
                        dly_cnt <= us_to_ticks(cm_lcd_pkg::DLY_CMD_US);
                        col     <= '0;
                        state   <= st_data;
                    end
                end

                st_data: begin
                    if (ready) begin
                        send    <= 1'b1;
                        cmd     <= '{rs: 1'b1, data: char_in};
                        dly_cnt <= us_to_ticks(cm_lcd_pkg::DLY_CMD_US);
                        col     <= col + 1'b1;     // Wraps after column 15
                        if (col == 4'd15) begin
                            line  <= ~line;
                            state <= line ? st_idle : st_addr;
                        end
                    end
                end

                st_idle: begin
                    if (pending && ready) begin
                        send    <= 1'b1;
                        cmd     <= '{rs: 1'b0, data: cm_lcd_pkg::CMD_CLEAR};
                        dly_cnt <= us_to_ticks(cm_lcd_pkg::DLY_CLEAR_US);
                        state   <= st_addr;
                    end
                end

                default: state <= st_powerup;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/cm_lcd_bus.sv
`timescale 1ns/1ps
`default_nettype none

module cm_lcd_bus #(
    parameter int unsigned TICKS_PER_US  = 50,
    parameter int unsigned E_PULSE_TICKS = 12
) (
    input  wire logic                 CLOCK_50,
    input  wire logic                 rst,
    input  wire cm_lcd_pkg::lcd_cmd_t cmd,
    input  wire logic                 send,
    output logic                      busy,
    output cm_lcd_pkg::lcd_char_t     lcd_data,
    output logic                      lcd_rs,
    output logic                      lcd_rw,
    output logic                      lcd_en,
    output logic                      lcd_on,
    output logic                      lcd_blon
);

    localparam cm_lcd_pkg::lcd_dly_t BUSY_TICKS =
        cm_lcd_pkg::lcd_dly_t'(cm_lcd_pkg::DLY_CMD_US * TICKS_PER_US);
    localparam cm_lcd_pkg::lcd_dly_t EN_OFF_AT =
        BUSY_TICKS - cm_lcd_pkg::lcd_dly_t'(E_PULSE_TICKS);

    cm_lcd_pkg::lcd_dly_t busy_cnt;   // Cycles left in the command

    assign lcd_rw   = 1'b0;    // Write only
    assign lcd_on   = 1'b1;
    assign lcd_blon = 1'b1;

    // Held for the whole command, so stable around the enable pulse
    always_ff @(posedge CLOCK_50) begin
        if (send && !busy) begin
            lcd_data <= cmd.data;
            lcd_rs   <= cmd.rs;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            busy     <= 1'b0;
            lcd_en   <= 1'b0;
            busy_cnt <= '0;
        end else if (send && !busy) begin
            busy     <= 1'b1;
            lcd_en   <= 1'b1;
            busy_cnt <= BUSY_TICKS - 1'b1;
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == EN_OFF_AT)
                lcd_en <= 1'b0;        // Falling edge latches the byte
            if (busy_cnt == cm_lcd_pkg::lcd_dly_t'(1))
                busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/cm_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module cm_display_top #(
    parameter int unsigned TICKS_PER_US      = 50,
    parameter int unsigned WARN_TOGGLE_TICKS = 50_000_000,   // About 1 s at 50 MHz
    parameter int unsigned E_PULSE_TICKS     = 12
) (
    input  wire logic                         CLOCK_50,
    input  wire logic                         rst,
    input  wire cm_status_pkg::cm_sensors_t   sensors,
    input  wire cm_status_pkg::cm_selection_t selection,
    output cm_lcd_pkg::lcd_char_t             lcd_data,
    output logic                              lcd_rs,
    output logic                              lcd_rw,
    output logic                              lcd_en,
    output logic                              lcd_on,
    output logic                              lcd_blon
);

    wire cm_status_pkg::msg_id_e msg_id;
    wire cm_lcd_pkg::lcd_cmd_t   cmd;
    wire cm_lcd_pkg::lcd_col_t   col;
    wire cm_lcd_pkg::lcd_char_t  char_out;
    wire logic                   line;
    wire logic                   send;
    wire logic                   busy;

    // ================================================
    // Message choice and text
    // ================================================
    cm_status_select #(
        .WARN_TOGGLE_TICKS(WARN_TOGGLE_TICKS)
    ) u_status_select (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .sensors  (sensors),
        .msg_id   (msg_id)
    );

    cm_msg_text u_msg_text (
        .msg_id    (msg_id),
        .selection (selection),
        .line      (line),
        .col       (col),
        .char_out  (char_out)
    );

    // ================================================
    // Display control and bus
    // ================================================
    cm_lcd_sequencer #(
        .TICKS_PER_US(TICKS_PER_US)
    ) u_sequencer (
        .CLOCK_50  (CLOCK_50),
        .rst       (rst),
        .msg_id    (msg_id),
        .selection (selection),
        .char_in   (char_out),
        .busy      (busy),
        .cmd       (cmd),
        .send      (send),
        .line      (line),
        .col       (col)
    );

    cm_lcd_bus #(
        .TICKS_PER_US  (TICKS_PER_US),
        .E_PULSE_TICKS (E_PULSE_TICKS)
    ) u_lcd_bus (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .cmd      (cmd),
        .send     (send),
        .busy     (busy),
        .lcd_data (lcd_data),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_en   (lcd_en),
        .lcd_on   (lcd_on),
        .lcd_blon (lcd_blon)
    );

endmodule

`default_nettype wire

//--- test/tb_lcd_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_model (
    input  wire cm_lcd_pkg::lcd_char_t lcd_data,
    input  wire logic                  lcd_rs,
    input  wire logic                  lcd_en,
    output cm_lcd_pkg::lcd_line_t      line1,
    output cm_lcd_pkg::lcd_line_t      line2,
    output logic [71:0]                instr_log,     // First nine instructions, oldest on top
    output int                         screen_count,  // Bumped after col 15 of line 2
    output int                         clear_count
);

    localparam cm_lcd_pkg::lcd_line_t BLANK = {16{8'h20}};

    // One process owns the whole model state
    initial begin
        int   instr_count;
        int   cur_col;
        logic cur_line;

        line1        = BLANK;
        line2        = BLANK;
        instr_log    = '0;
        screen_count = 0;
        clear_count  = 0;
        instr_count  = 0;
        cur_col      = 0;
        cur_line     = 1'b0;

        forever begin
            @(negedge lcd_en);              // Controller latches on the falling edge of E
            if (lcd_rs === 1'b0) begin
                if (instr_count < 9)
                    instr_log = {instr_log[63:0], lcd_data};
                instr_count++;
                case (lcd_data)
                    cm_lcd_pkg::CMD_CLEAR: begin
                        line1    = BLANK;
                        line2    = BLANK;
                        cur_line = 1'b0;
                        cur_col  = 0;
                        clear_count++;
                    end
                    cm_lcd_pkg::CMD_LINE1_ADDR: begin
                        cur_line = 1'b0;
                        cur_col  = 0;
                    end
                    cm_lcd_pkg::CMD_LINE2_ADDR: begin
                        cur_line = 1'b1;
                        cur_col  = 0;
                    end
                    default: ;                  // Mode bytes leave the buffer alone
                endcase
            end else if (lcd_rs === 1'b1 && cur_col < 16) begin
                if (cur_line)
                    line2[8 * (15 - cur_col) +: 8] = lcd_data;
                else
                    line1[8 * (15 - cur_col) +: 8] = lcd_data;
                if (cur_line && cur_col == 15)
                    screen_count++;
                cur_col++;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_cm_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cm_display;

    localparam int NUM_ROWS       = 24;
    localparam int RAND_FIRST     = 9;
    localparam int RAND_LAST      = 11;
    localparam int POWERUP_CYCLES = 25_000;    // 15 ms wait plus init commands at 1 tick/us
    localparam int WATCHDOG_NS    = (NUM_ROWS * 10_000 + POWERUP_CYCLES) * 20;
    localparam logic [71:0] INIT_LOG = 72'h30_30_30_38_08_01_06_0C_80;

    // Field order is paper(2) bin0 bin1 creamer cocoa pressure(2) status_ok
    localparam cm_status_pkg::cm_sensors_t S_OK      = 9'b11_0_0_0_0_01_1;
    localparam cm_status_pkg::cm_sensors_t S_MISSING = 9'b00_0_0_0_0_01_1;
    localparam cm_status_pkg::cm_sensors_t S_EMPTY   = 9'b01_0_0_0_0_01_1;
    localparam cm_status_pkg::cm_sensors_t S_FAULT   = 9'b11_0_0_0_0_11_1;
    localparam cm_status_pkg::cm_sensors_t S_HIGH    = 9'b11_0_0_0_0_10_1;
    localparam cm_status_pkg::cm_sensors_t S_HW      = 9'b11_0_0_0_0_01_0;
    localparam cm_status_pkg::cm_sensors_t S_TWO_A   = 9'b00_0_0_0_0_11_1;  // Missing and fault
    localparam cm_status_pkg::cm_sensors_t S_TWO_B   = 9'b11_0_0_0_0_10_0;  // High and hw
    localparam cm_status_pkg::cm_sensors_t S_WARN    = 9'b10_0_0_0_0_01_1;  // Paper almost empty

    typedef struct packed {
        cm_status_pkg::cm_sensors_t   sensors;
        cm_status_pkg::cm_selection_t selection;   // flavor, drink(3), size(2), brew(2)
        cm_lcd_pkg::lcd_line_t        line1;
        cm_lcd_pkg::lcd_line_t        line2;
    } row_t;

    logic                         CLOCK_50 = 1'b0;
    logic                         rst;
    cm_status_pkg::cm_sensors_t   sensors;
    cm_status_pkg::cm_selection_t selection;
    cm_lcd_pkg::lcd_char_t        lcd_data;
    logic                         lcd_rs;
    logic                         lcd_rw;
    logic                         lcd_en;
    logic                         lcd_on;
    logic                         lcd_blon;
    cm_lcd_pkg::lcd_line_t        line1;
    cm_lcd_pkg::lcd_line_t        line2;
    logic [71:0]                  instr_log;
    int                           screen_count;
    int                           clear_count;
    row_t                         rows [NUM_ROWS];
    int                           seed;

    always #10 CLOCK_50 = ~CLOCK_50;

    cm_display_top #(
        .TICKS_PER_US      (1),
        .WARN_TOGGLE_TICKS (20_000),
        .E_PULSE_TICKS     (4)
    ) u_dut (
        .CLOCK_50  (CLOCK_50),
        .rst       (rst),
        .sensors   (sensors),
        .selection (selection),
        .lcd_data  (lcd_data),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_en    (lcd_en),
        .lcd_on    (lcd_on),
        .lcd_blon  (lcd_blon)
    );

    tb_lcd_model u_model (
        .lcd_data     (lcd_data),
        .lcd_rs       (lcd_rs),
        .lcd_en       (lcd_en),
        .line1        (line1),
        .line2        (line2),
        .instr_log    (instr_log),
        .screen_count (screen_count),
        .clear_count  (clear_count)
    );

    task automatic check_equal(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s: got %h (\"%s\"), expected %h (\"%s\")",
                     $time, what, got, got, exp, exp);
            $display("Errors found");
            $fatal(1, "check failed: %s", what);
        end
    endtask

    // ================================================
    // Expected text from the display rules
    // ================================================
    function automatic cm_lcd_pkg::lcd_line_t to_line(input string s);
        cm_lcd_pkg::lcd_line_t r;
        r = {16{8'h20}};
        for (int i = 0; i < 16 && i < s.len(); i++)
            r[8 * (15 - i) +: 8] = s[i];
        return r;
    endfunction

    function automatic string normal_line1(input cm_status_pkg::cm_selection_t sel);
        string drink;
        string cup;
        case (sel.drink)
            3'd0:    drink = "MOCHA";
            3'd1:    drink = "LATTE";
            3'd2:    drink = "ESPR ";
            3'd3:    drink = "AMER ";
            3'd4:    drink = "DRIP ";
            default: drink = "UNKN ";
        endcase
        case (sel.size)
            2'd0:    cup = "10oz";
            2'd1:    cup = "16oz";
            2'd2:    cup = "20oz";
            default: cup = "??oz";
        endcase
        return $sformatf("C%0d %s %s", sel.flavor + 1, drink, cup);
    endfunction

    function automatic string normal_line2(input cm_status_pkg::cm_selection_t sel);
        case (sel.brew_state)
            2'd0:    return "Press START";
            2'd1:    return "HEATING...";
            2'd2:    return "BREWING...";
            default: return "READY";
        endcase
    endfunction

    task automatic build_table();
        cm_status_pkg::cm_selection_t sel;
        rows[0]  = '{S_OK, 8'b0_000_00_00, "C1 MOCHA 10oz   ", "Press START     "};
        rows[1]  = '{S_OK, 8'b0_000_00_01, "C1 MOCHA 10oz   ", "HEATING...      "};
        rows[2]  = '{S_OK, 8'b0_000_00_10, "C1 MOCHA 10oz   ", "BREWING...      "};
        rows[3]  = '{S_OK, 8'b0_000_00_11, "C1 MOCHA 10oz   ", "READY           "};
        rows[4]  = '{S_OK, 8'b1_001_01_00, "C2 LATTE 16oz   ", "Press START     "};
        rows[5]  = '{S_OK, 8'b0_010_10_00, "C1 ESPR  20oz   ", "Press START     "};
        rows[6]  = '{S_OK, 8'b1_011_11_01, "C2 AMER  ??oz   ", "HEATING...      "};
        rows[7]  = '{S_OK, 8'b0_100_00_10, "C1 DRIP  10oz   ", "BREWING...      "};
        rows[8]  = '{S_OK, 8'b1_110_01_11, "C2 UNKN  16oz   ", "READY           "};
        // Random selections that differ from the row before
        for (int i = RAND_FIRST; i <= RAND_LAST; i++) begin
            sel = 8'($random(seed));
            if (sel == rows[i - 1].selection)
                sel.flavor = ~sel.flavor;
            rows[i] = '{S_OK, sel, to_line(normal_line1(sel)), to_line(normal_line2(sel))};
        end
        rows[12] = '{S_MISSING, 8'b0_000_00_00, "Paper Filter NOT", "INSTALLED       "};
        rows[13] = '{S_EMPTY, 8'b0_000_00_00, "Paper Filter    ", "Empty           "};
        rows[14] = '{S_FAULT, 8'b0_000_00_00, "Water Pressure  ", "Error!          "};
        rows[15] = '{S_HIGH, 8'b0_000_00_00, "High Water      ", "Pressure        "};
        rows[16] = '{S_HW, 8'b0_000_00_00, "Hardware Status ", "Error - Service "};
        rows[17] = '{S_TWO_A, 8'b0_000_00_00, "Paper Filter NOT", "INSTALLED       "};
        rows[18] = '{S_TWO_B, 8'b0_000_00_00, "High Water      ", "Pressure        "};
        rows[19] = '{S_OK, 8'b0_001_00_00, "C1 LATTE 10oz   ", "Press START     "};
        // Warning rows 21 and 22 only wait for the alternation phase
        rows[20] = '{S_WARN, 8'b1_000_10_11, "C2 MOCHA 20oz   ", "READY           "};
        rows[21] = '{S_WARN, 8'b1_000_10_11, "Paper Filter Alm", "st Empty        "};
        rows[22] = '{S_WARN, 8'b1_000_10_11, "C2 MOCHA 20oz   ", "READY           "};
        rows[23] = '{S_OK, 8'b0_100_01_01, "C1 DRIP  16oz   ", "HEATING...      "};
    endtask

    // Bus pins that never move
    always @(negedge CLOCK_50) begin
        check_equal("lcd_rw", 128'(lcd_rw), 128'(1'b0));
        check_equal("lcd_on", 128'(lcd_on), 128'(1'b1));
        check_equal("lcd_blon", 128'(lcd_blon), 128'(1'b1));
    end

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        int start_screens;
        int start_clears;

        rst       = 1'b1;
        sensors   = S_OK;
        selection = '0;
        seed      = 32'hc5da_4caf;
        build_table();

        repeat (8) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        rst = 1'b0;
        check_equal("lcd_en after reset", 128'(lcd_en), 128'(1'b0));

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge CLOCK_50);
            start_screens = screen_count;
            start_clears  = clear_count;
            sensors       = rows[r].sensors;
            selection     = rows[r].selection;
            wait (screen_count != start_screens);
            @(negedge CLOCK_50);
            check_equal($sformatf("row %0d line 1", r), line1, rows[r].line1);
            check_equal($sformatf("row %0d line 2", r), line2, rows[r].line2);
            check_equal($sformatf("row %0d clears", r), 128'(clear_count - start_clears),
                        128'(1));
            if (r == 0)
                check_equal("init instruction log", 128'(instr_log), 128'(INIT_LOG));
        end

        $display("No errors");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Errors found");
        $fatal(1, "timeout: display never finished");
    end

endmodule

`default_nettype wire

//--- list.f
src/cm_status_pkg.sv
src/cm_lcd_pkg.sv
src/cm_status_select.sv
src/cm_msg_text.sv
src/cm_lcd_sequencer.sv
src/cm_lcd_bus.sv
src/cm_display_top.sv
test/tb_lcd_model.sv
test/tb_cm_display.sv

//--- Makefile
# Verilator build and run of the display testbench
TOP := tb_cm_display

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)

# Exit status of the simulation is the pass or fail result
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
